//--- src/segre_defines.svh
`ifndef SEGRE_DEFINES_SVH
`define SEGRE_DEFINES_SVH

// Datapath widths
`define SEGRE_WORD_SIZE 32
`define SEGRE_REG_SIZE 5
`define SEGRE_ADDR_SIZE 32

// Data cache geometry
`define SEGRE_DCACHE_WAYS 2
`define SEGRE_DCACHE_INDEX_SIZE 3
`define SEGRE_DCACHE_LANE_SIZE 128

// Derived address split
`define SEGRE_DCACHE_OFFSET_SIZE $clog2(`SEGRE_DCACHE_LANE_SIZE / 8)
`define SEGRE_DCACHE_TAG_SIZE \
    (`SEGRE_ADDR_SIZE - `SEGRE_DCACHE_INDEX_SIZE - `SEGRE_DCACHE_OFFSET_SIZE)

`endif

//--- src/segre_pkg.sv
`default_nettype none

`include "segre_defines.svh"

package segre_pkg;

    typedef logic [`SEGRE_WORD_SIZE-1:0]          word_t;
    typedef logic [`SEGRE_REG_SIZE-1:0]           reg_addr_t;
    typedef logic [`SEGRE_ADDR_SIZE-1:0]          addr_t;
    typedef logic [`SEGRE_DCACHE_LANE_SIZE-1:0]   lane_t;
    typedef logic [`SEGRE_DCACHE_INDEX_SIZE-1:0]  index_t;
    typedef logic [`SEGRE_DCACHE_OFFSET_SIZE-1:0] offset_t;
    typedef logic [`SEGRE_DCACHE_TAG_SIZE-1:0]    tag_t;
    typedef logic [`SEGRE_DCACHE_WAYS-1:0]        way_vec_t;

    typedef enum logic [1:0] {BYTE, HALF, WORD} memop_type_e;

    typedef enum logic {NO_BYPASS, BY_MEM_TL} bypass_e;

    typedef enum logic [1:0] {TL_RUN, TL_WRITEBACK, TL_REFILL} tl_state_e;

    // Input latch in front of the TL stage
    typedef struct packed {
        addr_t       addr;
        logic        rf_we;
        reg_addr_t   rf_waddr;
        word_t       st_data;
        logic        memop_rd;
        logic        memop_wr;
        logic        sign_ext;
        memop_type_e memop_type;
        bypass_e     bypass_b;
    } tl_stage_t;

    // Shared by all ways
    typedef struct packed {
        index_t index;
        tag_t   tag;
        lane_t  wr_lane;
        tag_t   wr_tag;
        logic   wr_dirty;
        logic   wr_valid;
    } way_req_t;

    typedef struct packed {
        logic  hit;
        logic  valid;
        logic  dirty;
        tag_t  tag;
        lane_t lane;
    } way_rsp_t;

    // TL to mem register, lane already selected
    typedef struct packed {
        logic        rf_we;
        reg_addr_t   rf_waddr;
        offset_t     offset;
        memop_type_e memop_type;
        logic        sign_ext;
        logic        memop_rd;
        way_vec_t    way_hit;
        lane_t       lane;
    } mem_stage_t;

endpackage : segre_pkg

`default_nettype wire

//--- src/segre_dcache_way.sv
`default_nettype none

`include "segre_defines.svh"

module segre_dcache_way (
    input  logic                clk_i,
    input  logic                reset_i,
    input  segre_pkg::way_req_t way_req_i,
    input  logic                we_i,
    output segre_pkg::way_rsp_t way_rsp_o
);
    import segre_pkg::*;

    localparam int unsigned SETS = 1 << `SEGRE_DCACHE_INDEX_SIZE;

    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;
    tag_t            tag_q  [SETS];
    lane_t           lane_q [SETS];

    // State bits per set
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (we_i) begin
            valid_q[way_req_i.index] <= way_req_i.wr_valid;
            dirty_q[way_req_i.index] <= way_req_i.wr_dirty;
        end
    end

    // Tag and lane arrays
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            tag_q[way_req_i.index]  <= way_req_i.wr_tag;
            lane_q[way_req_i.index] <= way_req_i.wr_lane;
        end
    end

    // Read and compare at the requested set
    always_comb begin
        way_rsp_o.valid = valid_q[way_req_i.index];
        way_rsp_o.dirty = dirty_q[way_req_i.index];
        way_rsp_o.tag   = tag_q[way_req_i.index];
        way_rsp_o.lane  = lane_q[way_req_i.index];
        way_rsp_o.hit   = valid_q[way_req_i.index]
                          && (tag_q[way_req_i.index] == way_req_i.tag);
    end

endmodule : segre_dcache_way

`default_nettype wire

//--- src/segre_tl_stage.sv
`default_nettype none

`include "segre_defines.svh"

module segre_tl_stage (
    input  logic                                          clk_i,
    input  logic                                          reset_i,
    input  segre_pkg::tl_stage_t                          tl_data_i,
    input  segre_pkg::word_t                              st_data_i,
    input  segre_pkg::way_rsp_t [`SEGRE_DCACHE_WAYS-1:0] way_rsp_i,
    output segre_pkg::way_req_t                           way_req_o,
    output segre_pkg::way_vec_t                           way_we_o,
    output segre_pkg::mem_stage_t                         mem_data_o,
    input  logic                                          mmu_data_rdy_i,
    input  segre_pkg::lane_t                              mmu_data_i,
    output logic                                          mmu_miss_o,
    output segre_pkg::addr_t                              mmu_addr_o,
    output logic                                          mmu_writeback_o,
    output segre_pkg::lane_t                              mmu_data_o,
    output logic                                          pipeline_hazard_o
);
    import segre_pkg::*;

    localparam int unsigned WAYS  = `SEGRE_DCACHE_WAYS;
    localparam int unsigned SETS  = 1 << `SEGRE_DCACHE_INDEX_SIZE;
    localparam int unsigned AGE_W = $clog2(WAYS);
    localparam int unsigned OFF_W = `SEGRE_DCACHE_OFFSET_SIZE;

    typedef logic [AGE_W-1:0] age_t;

    tl_state_e state_q, state_d;
    age_t      age_q [SETS][WAYS];

    tag_t      req_tag;
    index_t    req_index;
    offset_t   req_offset;
    logic      req_valid;
    way_vec_t  hit_vec;
    way_vec_t  victim_vec;
    lane_t     hit_lane;
    age_t      hit_age;
    lane_t     victim_lane;
    tag_t      victim_tag;
    logic      victim_dirty;
    lane_t     merged_lane;

    assign req_tag    = tl_data_i.addr[`SEGRE_ADDR_SIZE-1 -: `SEGRE_DCACHE_TAG_SIZE];
    assign req_index  = tl_data_i.addr[OFF_W +: `SEGRE_DCACHE_INDEX_SIZE];
    assign req_offset = tl_data_i.addr[OFF_W-1:0];
    assign req_valid  = tl_data_i.memop_rd || tl_data_i.memop_wr;

    // Hit lane and LRU victim of the current set
    always_comb begin
        hit_lane     = '0;
        hit_age      = '0;
        victim_lane  = '0;
        victim_tag   = '0;
        victim_dirty = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w]    = way_rsp_i[w].hit;
            victim_vec[w] = (age_q[req_index][w] == age_t'(WAYS - 1));
            if (hit_vec[w]) begin
                hit_lane |= way_rsp_i[w].lane;
                hit_age  |= age_q[req_index][w];
            end
            if (victim_vec[w]) begin
                victim_lane  |= way_rsp_i[w].lane;
                victim_tag   |= way_rsp_i[w].tag;
                victim_dirty |= way_rsp_i[w].valid && way_rsp_i[w].dirty;
            end
        end
    end

    // Store data merged into the hit lane
    always_comb begin
        merged_lane = hit_lane;
        case (tl_data_i.memop_type)
            BYTE:    merged_lane[{req_offset, 3'b000} +: 8]  = st_data_i[7:0];
            HALF:    merged_lane[{req_offset, 3'b000} +: 16] = st_data_i[15:0];
            default: merged_lane[{req_offset, 3'b000} +: 32] = st_data_i;
        endcase
    end

    assign pipeline_hazard_o = (state_q != TL_RUN) || (req_valid && !(|hit_vec));

    always_comb begin
        state_d            = state_q;
        way_req_o.index    = req_index;
        way_req_o.tag      = req_tag;
        way_req_o.wr_lane  = merged_lane;
        way_req_o.wr_tag   = req_tag;
        way_req_o.wr_dirty = 1'b1;
        way_req_o.wr_valid = 1'b1;
        way_we_o           = '0;
        mmu_miss_o         = 1'b0;
        mmu_writeback_o    = 1'b0;
        mmu_addr_o         = {req_tag, req_index, {OFF_W{1'b0}}};
        mmu_data_o         = victim_lane;
        case (state_q)
            TL_RUN: begin
                if (req_valid && !(|hit_vec)) begin
                    state_d = victim_dirty ? TL_WRITEBACK : TL_REFILL;
                end else if (tl_data_i.memop_wr) begin
                    way_we_o = hit_vec;
                end
            end
            TL_WRITEBACK: begin
                mmu_writeback_o = 1'b1;
                mmu_addr_o      = {victim_tag, req_index, {OFF_W{1'b0}}};
                state_d         = TL_REFILL;
            end
            default: begin
                mmu_miss_o = 1'b1;
                if (mmu_data_rdy_i) begin
                    // Refilled lane goes in clean
                    way_req_o.wr_lane  = mmu_data_i;
                    way_req_o.wr_dirty = 1'b0;
                    way_we_o           = victim_vec;
                    state_d            = TL_RUN;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= TL_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    // Age counters, zero is most recent
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    age_q[s][w] <= age_t'(w);
                end
            end
        end else if (state_q == TL_RUN && req_valid && (|hit_vec)) begin
            for (int w = 0; w < WAYS; w++) begin
                if (hit_vec[w]) begin
                    age_q[req_index][w] <= '0;
                end else if (age_q[req_index][w] < hit_age) begin
                    age_q[req_index][w] <= age_q[req_index][w] + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i || pipeline_hazard_o) begin
            mem_data_o.rf_we    <= 1'b0;
            mem_data_o.memop_rd <= 1'b0;
            mem_data_o.way_hit  <= '0;
        end else begin
            mem_data_o.rf_we      <= tl_data_i.rf_we;
            mem_data_o.memop_rd   <= tl_data_i.memop_rd;
            mem_data_o.way_hit    <= req_valid ? hit_vec : '0;
            mem_data_o.rf_waddr   <= tl_data_i.rf_waddr;
            mem_data_o.offset     <= req_offset;
            mem_data_o.memop_type <= tl_data_i.memop_type;
            mem_data_o.sign_ext   <= tl_data_i.sign_ext;
            mem_data_o.lane       <= hit_lane;
        end
    end

endmodule : segre_tl_stage

`default_nettype wire

//--- src/segre_mem_stage.sv
`default_nettype none

`include "segre_defines.svh"

module segre_mem_stage (
    input  logic                  clk_i,
    input  logic                  reset_i,
    input  segre_pkg::mem_stage_t mem_data_i,
    output segre_pkg::word_t      cache_data_o,
    output logic                  rf_we_o,
    output segre_pkg::reg_addr_t  rf_waddr_o
);
    import segre_pkg::*;

    localparam int unsigned W = `SEGRE_WORD_SIZE;

    lane_t shifted_lane;
    word_t load_data;
    logic  load_valid;

    // Bring the addressed bytes down to bit zero
    assign shifted_lane = mem_data_i.lane >> {mem_data_i.offset, 3'b000};

    assign load_valid = mem_data_i.memop_rd && (|mem_data_i.way_hit);

    always_comb begin
        case (mem_data_i.memop_type)
            BYTE: begin
                load_data = {{(W - 8){mem_data_i.sign_ext && shifted_lane[7]}},
                             shifted_lane[7:0]};
            end
            HALF: begin
                load_data = {{(W - 16){mem_data_i.sign_ext && shifted_lane[15]}},
                             shifted_lane[15:0]};
            end
            default: begin
                load_data = shifted_lane[W-1:0];
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rf_we_o <= 1'b0;
        end else begin
            rf_we_o <= load_valid && mem_data_i.rf_we;
        end
    end

    // Only loads move the result, bubbles leave it alone
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            cache_data_o <= '0;
        end else if (load_valid) begin
            cache_data_o <= load_data;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load_valid) begin
            rf_waddr_o <= mem_data_i.rf_waddr;
        end
    end

endmodule : segre_mem_stage

`default_nettype wire

//--- src/segre_mem_pipeline.sv
`default_nettype none

`include "segre_defines.svh"

module segre_mem_pipeline (
    input  logic                    clk_i,
    input  logic                    reset_i,

    // Request from execute
    input  segre_pkg::word_t        alu_src_a_i,
    input  segre_pkg::word_t        alu_src_b_i,
    input  logic                    rf_we_i,
    input  segre_pkg::reg_addr_t    rf_waddr_i,
    input  segre_pkg::word_t        rf_st_data_i,
    input  logic                    memop_rd_i,
    input  logic                    memop_wr_i,
    input  logic                    memop_sign_ext_i,
    input  segre_pkg::memop_type_e  memop_type_i,
    input  segre_pkg::bypass_e      bypass_b_i,

    // Writeback
    output segre_pkg::word_t        data_o,
    output logic                    rf_we_o,
    output segre_pkg::reg_addr_t    rf_waddr_o,

    // Outside memory
    input  logic                    mmu_data_rdy_i,
    input  segre_pkg::lane_t        mmu_data_i,
    output logic                    mmu_miss_o,
    output segre_pkg::addr_t        mmu_addr_o,
    output logic                    mmu_writeback_o,
    output segre_pkg::lane_t        mmu_data_o,

    output logic                    tl_hazard_o
);
    import segre_pkg::*;

    tl_stage_t                         tl_data_q;
    mem_stage_t                        mem_data;
    addr_t                             add_result;
    word_t                             tl_store_data;
    way_req_t                          way_req;
    way_vec_t                          way_we;
    way_rsp_t [`SEGRE_DCACHE_WAYS-1:0] way_rsp;

    assign add_result = alu_src_a_i + alu_src_b_i;

    // Most recent load result feeds a dependent store
    assign tl_store_data = (tl_data_q.bypass_b == BY_MEM_TL) ? data_o : tl_data_q.st_data;

    // Input latch holds while the TL stage stalls
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            tl_data_q.rf_we    <= 1'b0;
            tl_data_q.memop_rd <= 1'b0;
            tl_data_q.memop_wr <= 1'b0;
            tl_data_q.bypass_b <= NO_BYPASS;
        end else if (!tl_hazard_o) begin
            tl_data_q.addr       <= add_result;
            tl_data_q.rf_we      <= rf_we_i;
            tl_data_q.rf_waddr   <= rf_waddr_i;
            tl_data_q.st_data    <= rf_st_data_i;
            tl_data_q.memop_rd   <= memop_rd_i;
            tl_data_q.memop_wr   <= memop_wr_i;
            tl_data_q.sign_ext   <= memop_sign_ext_i;
            tl_data_q.memop_type <= memop_type_i;
            tl_data_q.bypass_b   <= bypass_b_i;
        end
    end

    segre_tl_stage i_tl_stage (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .tl_data_i         (tl_data_q),
        .st_data_i         (tl_store_data),
        .way_rsp_i         (way_rsp),
        .way_req_o         (way_req),
        .way_we_o          (way_we),
        .mem_data_o        (mem_data),
        .mmu_data_rdy_i    (mmu_data_rdy_i),
        .mmu_data_i        (mmu_data_i),
        .mmu_miss_o        (mmu_miss_o),
        .mmu_addr_o        (mmu_addr_o),
        .mmu_writeback_o   (mmu_writeback_o),
        .mmu_data_o        (mmu_data_o),
        .pipeline_hazard_o (tl_hazard_o)
    );

    for (genvar g = 0; g < `SEGRE_DCACHE_WAYS; g++) begin : gen_way
        segre_dcache_way i_way (
            .clk_i     (clk_i),
            .reset_i   (reset_i),
            .way_req_i (way_req),
            .we_i      (way_we[g]),
            .way_rsp_o (way_rsp[g])
        );
    end

    segre_mem_stage i_mem_stage (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .mem_data_i   (mem_data),
        .cache_data_o (data_o),
        .rf_we_o      (rf_we_o),
        .rf_waddr_o   (rf_waddr_o)
    );

endmodule : segre_mem_pipeline

`default_nettype wire

//--- test/segre_tb_clock.sv
`default_nettype none

module segre_tb_clock (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int RESET_CYCLES = 10;

    // 4 ns period
    initial begin
        clk_o = 1'b0;
        forever begin
            #2 clk_o = ~clk_o;
        end
    end

    // Reset drops on a falling edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;
    end

endmodule : segre_tb_clock

`default_nettype wire

//--- test/segre_mem_pipeline_sva.sv
`default_nettype none

module segre_mem_pipeline_sva (
    input logic clk_i,
    input logic reset_i,
    input logic tl_hazard_i,
    input logic mmu_miss_i,
    input logic mmu_writeback_i,
    input logic mmu_data_rdy_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // A pending refill always stalls the pipeline
    miss_holds_hazard: assert property (
        @(posedge clk_i) disable iff (reset_i)
        mmu_miss_i |-> tl_hazard_i
    ) else $error("mmu_miss_o high while tl_hazard_o is low");

    writeback_or_miss: assert property (
        @(posedge clk_i) disable iff (reset_i)
        !(mmu_writeback_i && mmu_miss_i)
    ) else $error("mmu_writeback_o and mmu_miss_o high together");

    ready_only_on_miss: assert property (
        @(posedge clk_i) disable iff (reset_i)
        mmu_data_rdy_i |-> mmu_miss_i
    ) else $error("mmu_data_rdy_i high without mmu_miss_o");

endmodule : segre_mem_pipeline_sva

`default_nettype wire

//--- test/segre_mem_pipeline_tb.sv
`default_nettype none

module segre_mem_pipeline_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import segre_pkg::*;

    localparam int    TIMEOUT = 100;
    localparam addr_t BASE    = 32'h0000_1000;
    localparam int    SPAN    = 512;
    localparam int    N_RAND  = 400;

    typedef struct packed {
        addr_t       addr;
        logic        rd;
        logic        wr;
        memop_type_e mtype;
        logic        sign_ext;
        bypass_e     bypass;
        reg_addr_t   waddr;
        word_t       st_data;
        logic        timed;
    } req_t;

    typedef struct packed {
        word_t       data;
        reg_addr_t   waddr;
        logic        timed;
        logic [31:0] accept_cycle;
    } load_exp_t;

    logic        clk_i;
    logic        reset_i;
    word_t       alu_src_a_i;
    word_t       alu_src_b_i;
    logic        rf_we_i;
    reg_addr_t   rf_waddr_i;
    word_t       rf_st_data_i;
    logic        memop_rd_i;
    logic        memop_wr_i;
    logic        memop_sign_ext_i;
    memop_type_e memop_type_i;
    bypass_e     bypass_b_i;
    word_t       data_o;
    logic        rf_we_o;
    reg_addr_t   rf_waddr_o;
    logic        mmu_data_rdy_i;
    lane_t       mmu_data_i;
    logic        mmu_miss_o;
    addr_t       mmu_addr_o;
    logic        mmu_writeback_o;
    lane_t       mmu_data_o;
    logic        tl_hazard_o;

    logic [7:0]  ref_mem [addr_t];
    lane_t       lane_mem [addr_t];
    load_exp_t   exp_q [$];
    load_exp_t   exp_head;
    int          read_idx = 0;
    word_t       last_load;
    logic [31:0] cycle_count = '0;
    int          refill_delay;
    req_t        req;

    segre_tb_clock i_clock (
        .clk_o   (clk_i),
        .reset_o (reset_i)
    );

    segre_mem_pipeline i_segre_mem_pipeline (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .alu_src_a_i      (alu_src_a_i),
        .alu_src_b_i      (alu_src_b_i),
        .rf_we_i          (rf_we_i),
        .rf_waddr_i       (rf_waddr_i),
        .rf_st_data_i     (rf_st_data_i),
        .memop_rd_i       (memop_rd_i),
        .memop_wr_i       (memop_wr_i),
        .memop_sign_ext_i (memop_sign_ext_i),
        .memop_type_i     (memop_type_i),
        .bypass_b_i       (bypass_b_i),
        .data_o           (data_o),
        .rf_we_o          (rf_we_o),
        .rf_waddr_o       (rf_waddr_o),
        .mmu_data_rdy_i   (mmu_data_rdy_i),
        .mmu_data_i       (mmu_data_i),
        .mmu_miss_o       (mmu_miss_o),
        .mmu_addr_o       (mmu_addr_o),
        .mmu_writeback_o  (mmu_writeback_o),
        .mmu_data_o       (mmu_data_o),
        .tl_hazard_o      (tl_hazard_o)
    );

    bind segre_mem_pipeline segre_mem_pipeline_sva i_segre_mem_pipeline_sva (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .tl_hazard_i     (tl_hazard_o),
        .mmu_miss_i      (mmu_miss_o),
        .mmu_writeback_i (mmu_writeback_o),
        .mmu_data_rdy_i  (mmu_data_rdy_i)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR @%0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_reg(input reg_addr_t got, input reg_addr_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR @%0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic check_lane(input lane_t got, input lane_t exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR @%0t: %s is %h, expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            stop_on_error($sformatf("ERR @%0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // Untouched memory content, mixes every address bit
    function automatic logic [7:0] fill_byte(input addr_t a);
        return {a[3:0], a[7:4]} ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
    endfunction

    function automatic logic [7:0] read_byte(input addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return fill_byte(a);
    endfunction

    function automatic int size_of(input memop_type_e t);
        case (t)
            BYTE:    return 1;
            HALF:    return 2;
            default: return 4;
        endcase
    endfunction

    // Lane as the reference model sees it, byte 0 in the low bits
    function automatic lane_t model_lane(input addr_t base);
        lane_t l;
        l = '0;
        for (int i = 0; i < $bits(lane_t) / 8; i++) begin
            l = {read_byte(base + i), l[$bits(lane_t)-1:8]};
        end
        return l;
    endfunction

    function automatic lane_t memory_lane(input addr_t base);
        lane_t l;
        l = '0;
        if (lane_mem.exists(base)) begin
            return lane_mem[base];
        end
        for (int i = 0; i < $bits(lane_t) / 8; i++) begin
            l = {fill_byte(base + i), l[$bits(lane_t)-1:8]};
        end
        return l;
    endfunction

    function automatic word_t predict_load(input req_t r);
        word_t v;
        v = {read_byte(r.addr + 3), read_byte(r.addr + 2),
             read_byte(r.addr + 1), read_byte(r.addr)};
        case (r.mtype)
            BYTE:    v = r.sign_ext ? {{24{v[7]}}, v[7:0]} : {24'h0, v[7:0]};
            HALF:    v = r.sign_ext ? {{16{v[15]}}, v[15:0]} : {16'h0, v[15:0]};
            default: v = v;
        endcase
        return v;
    endfunction

    task automatic random_request(output req_t r);
        int unsigned kind;
        int unsigned offset;
        kind       = $urandom_range(99);
        r          = '0;
        r.mtype    = memop_type_e'(2'($urandom_range(2)));
        r.sign_ext = 1'($urandom);
        r.waddr    = reg_addr_t'($urandom);
        r.st_data  = $urandom;
        offset     = $urandom_range(SPAN - 1) & ~(size_of(r.mtype) - 1);
        r.addr     = BASE + offset;
        r.rd       = kind < 45;
        r.wr       = kind >= 45 && kind < 85;
        if (r.wr && $urandom_range(3) == 0) begin
            r.bypass = BY_MEM_TL;
        end
    endtask

    // Drive on the falling edge and hold through the stall
    task automatic issue(input req_t r);
        int        waited;
        load_exp_t e;
        word_t     st;
        waited           = 0;
        alu_src_a_i      = $urandom;
        alu_src_b_i      = r.addr - alu_src_a_i;
        rf_we_i          = r.rd;
        rf_waddr_i       = r.waddr;
        rf_st_data_i     = r.st_data;
        memop_rd_i       = r.rd;
        memop_wr_i       = r.wr;
        memop_sign_ext_i = r.sign_ext;
        memop_type_i     = r.mtype;
        bypass_b_i       = r.bypass;
        while (tl_hazard_o) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_error($sformatf("Timeout: request to %h was never accepted", r.addr));
            end
        end
        // Taken at the coming rising edge
        if (r.wr) begin
            st = (r.bypass == BY_MEM_TL) ? last_load : r.st_data;
            for (int i = 0; i < size_of(r.mtype); i++) begin
                ref_mem[r.addr + i] = st[7:0];
                st = st >> 8;
            end
        end
        if (r.rd) begin
            e.data         = predict_load(r);
            e.waddr        = r.waddr;
            e.timed        = r.timed;
            e.accept_cycle = cycle_count + 1;
            last_load      = e.data;
            exp_q.push_back(e);
        end
        @(negedge clk_i);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        issue('0);
        while (read_idx != exp_q.size() || tl_hazard_o) begin
            @(negedge clk_i);
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_error("Timeout: outstanding loads never returned a result");
            end
        end
    endtask

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
    end

    // Outside memory, answers each miss after 1 to 8 cycles
    initial begin
        mmu_data_rdy_i = 1'b0;
        mmu_data_i     = '0;
        refill_delay   = 0;
        forever begin
            @(negedge clk_i);
            mmu_data_rdy_i = 1'b0;
            if (!reset_i && mmu_writeback_o) begin
                check_lane(mmu_data_o, model_lane(mmu_addr_o), "writeback lane");
                lane_mem[mmu_addr_o] = mmu_data_o;
            end
            if (!reset_i && mmu_miss_o) begin
                if (refill_delay == 0) begin
                    refill_delay = $urandom_range(8, 1);
                end
                refill_delay--;
                if (refill_delay == 0) begin
                    mmu_data_i     = memory_lane(mmu_addr_o);
                    mmu_data_rdy_i = 1'b1;
                end
            end
        end
    end

    always @(negedge clk_i) begin
        if (!reset_i && rf_we_o) begin
            if (read_idx >= exp_q.size()) begin
                stop_on_error("rf_we_o pulsed while no load was outstanding");
            end else begin
                exp_head = exp_q[read_idx];
                read_idx++;
                check_reg(rf_waddr_o, exp_head.waddr, "rf_waddr_o");
                check_word(data_o, exp_head.data, "data_o");
                if (exp_head.timed && cycle_count != exp_head.accept_cycle + 2) begin
                    stop_on_error("A load hit did not return two edges after acceptance");
                end
            end
        end
    end

    initial begin
        int waited;
        void'($urandom(32'hac49_478a));
        alu_src_a_i      = '0;
        alu_src_b_i      = '0;
        rf_we_i          = 1'b0;
        rf_waddr_i       = '0;
        rf_st_data_i     = '0;
        memop_rd_i       = 1'b0;
        memop_wr_i       = 1'b0;
        memop_sign_ext_i = 1'b0;
        memop_type_i     = BYTE;
        bypass_b_i       = NO_BYPASS;
        last_load        = '0;
        waited           = 0;
        do begin
            @(posedge clk_i);
            waited++;
            if (waited > TIMEOUT) begin
                stop_on_error("Timeout: reset was never released");
            end
        end while (reset_i);
        @(negedge clk_i);
        check_bit(tl_hazard_o, 1'b0, "tl_hazard_o after reset");
        check_bit(mmu_miss_o, 1'b0, "mmu_miss_o after reset");
        check_bit(mmu_writeback_o, 1'b0, "mmu_writeback_o after reset");
        check_bit(rf_we_o, 1'b0, "rf_we_o after reset");
        check_word(data_o, '0, "data_o after reset");

        // Miss then a timed hit on the same word
        req       = '0;
        req.rd    = 1'b1;
        req.mtype = WORD;
        req.addr  = BASE + 32'h40;
        req.waddr = 5'd1;
        issue(req);
        drain();
        req.timed = 1'b1;
        req.waddr = 5'd2;
        issue(req);
        drain();

        for (int n = 0; n < N_RAND; n++) begin
            random_request(req);
            // Let the previous load land in data_o first
            if (req.bypass == BY_MEM_TL) begin
                issue('0);
            end
            issue(req);
        end
        drain();

        // Read back the whole range
        for (int a = 0; a < SPAN; a += 4) begin
            req       = '0;
            req.rd    = 1'b1;
            req.mtype = WORD;
            req.addr  = BASE + a;
            req.waddr = reg_addr_t'(a >> 2);
            issue(req);
        end
        drain();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule : segre_mem_pipeline_tb

`default_nettype wire

//--- files.f
+incdir+src
src/segre_pkg.sv
src/segre_dcache_way.sv
src/segre_tl_stage.sv
src/segre_mem_stage.sv
src/segre_mem_pipeline.sv
test/segre_tb_clock.sv
test/segre_mem_pipeline_sva.sv
test/segre_mem_pipeline_tb.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    --top-module segre_mem_pipeline_tb \
    --Mdir obj_dir -o segre_sim \
    -f files.f \
    && ./obj_dir/segre_sim | tee /dev/stderr | grep -qF "TEST RESULT: PASS" \
    && echo "Simulation passed" \
    || { echo "Simulation failed" >&2; exit 1; }
